/* design/sram_axi_pkg.sv */
package sram_axi_pkg;

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int STRB_W     = DATA_W / 8;
    localparam int LEN_W      = 8;
    localparam int SIZE_W     = 3;
    localparam int WORD_IDX_W = 14;
    localparam int REGION_W   = 16;
    localparam int OFFSET_W   = 2;

    // Burst types, WRAP is handled like FIXED
    localparam logic [1:0] BURST_FIXED = 2'b00;
    localparam logic [1:0] BURST_INCR  = 2'b01;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    // Upper address half selects the region
    localparam logic [REGION_W-1:0] RO_REGION = 16'h0000;
    localparam logic [REGION_W-1:0] RW_REGION = 16'h0001;

    localparam logic [SIZE_W-1:0] SIZE_LIMIT = 3'd3; // Doubleword and up rejected

    // Flat view for stepping, field view for decode
    typedef union packed {
        logic [ADDR_W-1:0] flat;
        struct packed {
            logic [REGION_W-1:0]   region;
            logic [WORD_IDX_W-1:0] idx;
            logic [OFFSET_W-1:0]   offset;
        } f;
    } axi_addr_u;

endpackage

/* design/axi_request_ctrl.sv */
module axi_request_ctrl
    import sram_axi_pkg::*;
#(
    parameter int ID_WIDTH = 4
) (
    input  logic                  ACLK,
    input  logic                  ARESETn,

    input  logic [ID_WIDTH-1:0]   AWID,
    input  logic [ADDR_W-1:0]     AWADDR,
    input  logic [LEN_W-1:0]      AWLEN,
    input  logic [SIZE_W-1:0]     AWSIZE,
    input  logic [1:0]            AWBURST,
    input  logic                  AWVALID,
    output logic                  AWREADY,

    input  logic [DATA_W-1:0]     WDATA,
    input  logic [STRB_W-1:0]     WSTRB,
    input  logic                  WLAST,
    input  logic                  WVALID,
    output logic                  WREADY,

    output logic [ID_WIDTH-1:0]   BID,
    output logic [1:0]            BRESP,
    output logic                  BVALID,
    input  logic                  BREADY,

    input  logic [ID_WIDTH-1:0]   ARID,
    input  logic [ADDR_W-1:0]     ARADDR,
    input  logic [LEN_W-1:0]      ARLEN,
    input  logic [SIZE_W-1:0]     ARSIZE,
    input  logic [1:0]            ARBURST,
    input  logic                  ARVALID,
    output logic                  ARREADY,

    output logic                  mem_en,
    output logic [STRB_W-1:0]     mem_we,
    output logic [WORD_IDX_W-1:0] mem_idx,
    output logic [DATA_W-1:0]     mem_wdata,

    output logic                  beat_issue,
    output logic [1:0]            beat_resp,
    output logic                  beat_last,
    output logic [ID_WIDTH-1:0]   beat_id,
    output logic                  beat_data_ok,
    input  logic                  beat_done
);

    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_WDATA  = 3'd1;
    localparam logic [2:0] S_WRESP  = 3'd2;
    localparam logic [2:0] S_RISSUE = 3'd3;
    localparam logic [2:0] S_RWAIT  = 3'd4;

    logic [2:0]          state;
    logic [2:0]          state_nxt;
    logic [LEN_W-1:0]    beats_left;

    axi_addr_u           in_addr;
    axi_addr_u           cur_addr;
    logic [SIZE_W-1:0]   in_size;
    logic [SIZE_W-1:0]   cur_size;
    logic [1:0]          cur_burst;
    logic [ID_WIDTH-1:0] cur_id;
    logic [1:0]          in_resp;
    logic [1:0]          cur_resp;

    logic aw_take;
    logic ar_take;
    logic w_take;
    logic allowed;

    assign AWREADY = (state == S_IDLE);
    assign ARREADY = (state == S_IDLE) && !AWVALID; // AW wins a tie
    assign WREADY  = (state == S_WDATA);
    assign BVALID  = (state == S_WRESP);
    assign BID     = cur_id;
    assign BRESP   = cur_resp;

    assign aw_take = AWVALID && AWREADY;
    assign ar_take = ARVALID && ARREADY;
    assign w_take  = WVALID && WREADY;
    assign allowed = (cur_resp == RESP_OKAY);

    // Region and size decode, done once per burst
    assign in_addr.flat = AWVALID ? AWADDR : ARADDR;
    assign in_size      = AWVALID ? AWSIZE : ARSIZE;

    always_comb begin
        if (in_size >= SIZE_LIMIT)
            in_resp = RESP_SLVERR;
        else if (in_addr.f.region == RW_REGION)
            in_resp = RESP_OKAY;
        else if (in_addr.f.region == RO_REGION)
            in_resp = AWVALID ? RESP_SLVERR : RESP_OKAY; // Read-only half
        else
            in_resp = RESP_DECERR;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (aw_take)
                    state_nxt = S_WDATA;
                else if (ar_take)
                    state_nxt = S_RISSUE;
            end
            S_WDATA:  if (w_take && WLAST) state_nxt = S_WRESP;
            S_WRESP:  if (BREADY) state_nxt = S_IDLE;
            S_RISSUE: state_nxt = S_RWAIT;
            S_RWAIT: begin
                if (beat_done)
                    state_nxt = (beats_left == '0) ? S_IDLE : S_RISSUE;
            end
            default:  state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state      <= S_IDLE;
            beats_left <= '0;
        end else begin
            state <= state_nxt;
            if (ar_take)
                beats_left <= ARLEN;
            else if (beat_done)
                beats_left <= beats_left - 1'b1;
        end
    end

    always_ff @(posedge ACLK) begin
        if (aw_take || ar_take) begin
            cur_addr  <= in_addr;
            cur_size  <= in_size;
            cur_burst <= AWVALID ? AWBURST : ARBURST;
            cur_id    <= AWVALID ? AWID : ARID;
            cur_resp  <= in_resp;
        end else if (w_take || beat_issue) begin
            case (cur_burst)
                BURST_FIXED: cur_addr <= cur_addr;
                BURST_INCR:  cur_addr.flat <= cur_addr.flat + (ADDR_W'(1) << cur_size);
                default:     cur_addr <= cur_addr; // WRAP stays put
            endcase
        end
    end

    // Low-aligned strobe and data moved up to the byte offset
    assign mem_en    = allowed && (w_take || beat_issue);
    assign mem_we    = (allowed && w_take) ? (WSTRB << cur_addr.f.offset) : '0;
    assign mem_wdata = WDATA << {cur_addr.f.offset, 3'b000};
    assign mem_idx   = cur_addr.f.idx;

    assign beat_issue   = (state == S_RISSUE);
    assign beat_resp    = cur_resp;
    assign beat_last    = (beats_left == '0);
    assign beat_id      = cur_id;
    assign beat_data_ok = allowed;

    // Address channels shut as soon as a burst is taken
    a_addr_ready_idle: assert property (@(posedge ACLK) disable iff (!ARESETn)
        (aw_take || ar_take) |=> !AWREADY && !ARREADY);

    a_bvalid_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        BVALID && !BREADY |=> BVALID && $stable(BRESP) && $stable(BID));

endmodule

/* design/sram_array.sv */
module sram_array
    import sram_axi_pkg::*;
(
    input  logic                  ACLK,
    input  logic                  mem_en,
    input  logic [STRB_W-1:0]     mem_we,
    input  logic [WORD_IDX_W-1:0] mem_idx,
    input  logic [DATA_W-1:0]     mem_wdata,
    output logic [DATA_W-1:0]     mem_rdata
);

    localparam int DEPTH = 1 << WORD_IDX_W;

    logic [DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge ACLK) begin
        if (mem_en) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (mem_we[b])
                    mem[mem_idx][8*b +: 8] <= mem_wdata[8*b +: 8];
            end
            if (mem_we == '0)
                mem_rdata <= mem[mem_idx]; // Read port, one cycle latency
        end
    end

    // Enables only reach the array through a selected access
    a_we_needs_en: assert property (@(posedge ACLK)
        (mem_we != '0) |-> mem_en);

endmodule

/* design/read_return.sv */
module read_return
    import sram_axi_pkg::*;
#(
    parameter int ID_WIDTH = 4
) (
    input  logic                ACLK,
    input  logic                ARESETn,

    input  logic                beat_issue,
    input  logic [1:0]          beat_resp,
    input  logic                beat_last,
    input  logic [ID_WIDTH-1:0] beat_id,
    input  logic                beat_data_ok,
    input  logic [DATA_W-1:0]   mem_rdata,

    output logic [ID_WIDTH-1:0] RID,
    output logic [DATA_W-1:0]   RDATA,
    output logic [1:0]          RRESP,
    output logic                RLAST,
    output logic                RVALID,
    input  logic                RREADY,

    output logic                beat_done
);

    logic              fresh;      // First cycle of a beat, array output live
    logic              data_ok_q;
    logic [DATA_W-1:0] data_q;

    assign beat_done = RVALID && RREADY;

    // Array word straight through on the first cycle, held copy afterwards
    assign RDATA = fresh ? (data_ok_q ? mem_rdata : '0) : data_q;

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            RVALID <= 1'b0;
            RLAST  <= 1'b0;
            fresh  <= 1'b0;
        end else begin
            fresh <= beat_issue;
            if (beat_issue) begin
                RVALID <= 1'b1;
                RLAST  <= beat_last;
            end else if (beat_done) begin
                RVALID <= 1'b0;
                RLAST  <= 1'b0;
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (beat_issue) begin
            RID       <= beat_id;
            RRESP     <= beat_resp;
            data_ok_q <= beat_data_ok;
        end
        if (fresh)
            data_q <= RDATA;
    end

    a_r_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
        RVALID && !RREADY |=> RVALID && $stable(RDATA) && $stable(RRESP));

endmodule

/* design/sram_axi_top.sv */
module sram_axi_top
    import sram_axi_pkg::*;
#(
    parameter int ID_WIDTH = 4
) (
    input  logic                ACLK,
    input  logic                ARESETn,

    input  logic [ID_WIDTH-1:0] AWID,
    input  logic [ADDR_W-1:0]   AWADDR,
    input  logic [LEN_W-1:0]    AWLEN,
    input  logic [SIZE_W-1:0]   AWSIZE,
    input  logic [1:0]          AWBURST,
    input  logic                AWVALID,
    output logic                AWREADY,

    input  logic [DATA_W-1:0]   WDATA,
    input  logic [STRB_W-1:0]   WSTRB,
    input  logic                WLAST,
    input  logic                WVALID,
    output logic                WREADY,

    output logic [ID_WIDTH-1:0] BID,
    output logic [1:0]          BRESP,
    output logic                BVALID,
    input  logic                BREADY,

    input  logic [ID_WIDTH-1:0] ARID,
    input  logic [ADDR_W-1:0]   ARADDR,
    input  logic [LEN_W-1:0]    ARLEN,
    input  logic [SIZE_W-1:0]   ARSIZE,
    input  logic [1:0]          ARBURST,
    input  logic                ARVALID,
    output logic                ARREADY,

    output logic [ID_WIDTH-1:0] RID,
    output logic [DATA_W-1:0]   RDATA,
    output logic [1:0]          RRESP,
    output logic                RLAST,
    output logic                RVALID,
    input  logic                RREADY
);

    // Request control to array
    logic                  mem_en;
    logic [STRB_W-1:0]     mem_we;
    logic [WORD_IDX_W-1:0] mem_idx;
    logic [DATA_W-1:0]     mem_wdata;
    logic [DATA_W-1:0]     mem_rdata;

    // Read beat hand-off
    logic                  beat_issue;
    logic [1:0]            beat_resp;
    logic                  beat_last;
    logic [ID_WIDTH-1:0]   beat_id;
    logic                  beat_data_ok;
    logic                  beat_done;

    // Port and wire names line up one to one
    axi_request_ctrl #(
        .ID_WIDTH (ID_WIDTH)
    ) req_ctrl_i (.*);

    sram_array mem_i (.*);

    read_return #(
        .ID_WIDTH (ID_WIDTH)
    ) rd_ret_i (.*);

endmodule

/* bench/axi_checker.sv */
module axi_checker
    import sram_axi_pkg::*;
#(
    parameter int ID_WIDTH = 4
) (
    input  logic                ACLK,
    input  logic                ARESETn,
    input  logic [ID_WIDTH-1:0] AWID, ARID, BID, RID,
    input  logic [ADDR_W-1:0]   AWADDR, ARADDR,
    input  logic [LEN_W-1:0]    ARLEN,
    input  logic [SIZE_W-1:0]   AWSIZE, ARSIZE,
    input  logic [1:0]          AWBURST, ARBURST, BRESP, RRESP,
    input  logic [DATA_W-1:0]   WDATA, RDATA,
    input  logic [STRB_W-1:0]   WSTRB,
    input  logic                AWVALID, AWREADY, WVALID, WREADY, WLAST, BVALID, BREADY,
    input  logic                ARVALID, ARREADY, RVALID, RREADY, RLAST,
    input  logic [1:0]          exp_resp,    // Response column of the current row
    output int                  err_count,
    output int                  check_count,
    output int                  rows_done
);

    logic [DATA_W-1:0]   model [1 << WORD_IDX_W];
    axi_addr_u           wr_addr;
    axi_addr_u           rd_addr;
    logic [SIZE_W-1:0]   wr_size, rd_size;
    logic [1:0]          wr_burst, rd_burst, wr_resp, rd_resp;
    logic [ID_WIDTH-1:0] wr_id, rd_id, held_id;
    logic [LEN_W-1:0]    rd_len;
    logic [DATA_W-1:0]   held_data;
    logic [1:0]          held_resp;
    logic                held_last;
    logic                stalled;
    logic                aw_prev;
    logic                wlast_prev;
    logic                idle_due;
    logic                r_end;
    int                  rv_wait;    // Edges until the next RVALID is due
    int                  rd_beat;
    int                  row_errs;

    initial begin
        err_count   = 0;
        check_count = 0;
        rows_done   = 0;
        row_errs    = 0;
        stalled     = 1'b0;
        aw_prev     = 1'b0;
        wlast_prev  = 1'b0;
        idle_due    = 1'b1;  // Reset leaves the slave idle
        r_end       = 1'b0;
        rv_wait     = 0;
    end

    function automatic logic [1:0] rule_resp(axi_addr_u a, logic [SIZE_W-1:0] size,
                                             logic is_write);
        if (size >= SIZE_LIMIT)
            return RESP_SLVERR;
        if (a.f.region == RW_REGION)
            return RESP_OKAY;
        if (a.f.region == RO_REGION)
            return is_write ? RESP_SLVERR : RESP_OKAY;
        return RESP_DECERR;
    endfunction

    function automatic axi_addr_u next_addr(axi_addr_u a, logic [SIZE_W-1:0] size,
                                            logic [1:0] burst);
        axi_addr_u n;
        n = a;
        if (burst == BURST_INCR)
            n.flat = a.flat + (32'd1 << size);  // FIXED and WRAP stay put
        return n;
    endfunction

    // Lane b takes strobe bit b-off, anything past the top lane is lost
    function automatic logic [DATA_W-1:0] merge_lanes(logic [DATA_W-1:0] old,
            logic [DATA_W-1:0] data, logic [STRB_W-1:0] strb, int off);
        logic [DATA_W-1:0] w;
        w = old;
        for (int b = off; b < STRB_W; b++) begin
            if (strb[b-off])
                w[8*b +: 8] = data[8*(b-off) +: 8];
        end
        return w;
    endfunction

    task automatic compare(input string name, input logic [DATA_W-1:0] exp,
                           input logic [DATA_W-1:0] act);
        check_count++;
        if (exp !== act) begin
            err_count++;
            $display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic close_row(input string kind, input logic [ID_WIDTH-1:0] id,
                             input logic [1:0] rule);
        check_count++;
        if (rule !== exp_resp) begin
            err_count++;
            $display("Row %0d: table response %0d does not match the address rules (%0d)",
                     rows_done, exp_resp, rule);
        end
        $display("Row %0d %s id=%0h resp=%0d: %s", rows_done, kind, id, rule,
                 (err_count == row_errs) ? "passed" : "failed");
        rows_done++;
        row_errs = err_count;
    endtask

    always @(posedge ACLK) begin
        if (ARESETn) begin
            if (stalled) begin   // Payload must not move while RREADY is low
                compare("RVALID", 1'b1, RVALID);
                compare("RDATA", held_data, RDATA);
                compare("RRESP", held_resp, RRESP);
                compare("RLAST", held_last, RLAST);
                compare("RID", held_id, RID);
            end
            if (aw_prev)
                compare("WREADY", 1'b1, WREADY);
            if (wlast_prev)
                compare("BVALID", 1'b1, BVALID);
            if (idle_due) begin  // No address is pending here
                compare("AWREADY", 1'b1, AWREADY);
                compare("ARREADY", 1'b1, ARREADY);
            end
            if (r_end)
                compare("RVALID", 1'b0, RVALID); // Nothing after the last beat
            if (rv_wait > 0) begin
                rv_wait--;
                compare("RVALID", rv_wait == 0, RVALID);
            end
            r_end = 1'b0;
            if (AWVALID && AWREADY) begin
                wr_addr.flat = AWADDR;
                wr_size      = AWSIZE;
                wr_burst     = AWBURST;
                wr_id        = AWID;
                wr_resp      = rule_resp(wr_addr, AWSIZE, 1'b1);
            end
            if (WVALID && WREADY) begin
                if (wr_resp == RESP_OKAY)
                    model[wr_addr.f.idx] = merge_lanes(model[wr_addr.f.idx], WDATA, WSTRB,
                                                       int'(wr_addr.f.offset));
                wr_addr = next_addr(wr_addr, wr_size, wr_burst);
            end
            if (BVALID && BREADY) begin
                compare("BRESP", wr_resp, BRESP);
                compare("BID", wr_id, BID);
                close_row("write", wr_id, wr_resp);
            end
            if (ARVALID && ARREADY) begin
                rd_addr.flat = ARADDR;
                rd_size      = ARSIZE;
                rd_burst     = ARBURST;
                rd_id        = ARID;
                rd_len       = ARLEN;
                rd_resp      = rule_resp(rd_addr, ARSIZE, 1'b0);
                rd_beat      = 0;
                rv_wait      = 2;
            end
            if (RVALID && RREADY) begin
                compare("RDATA", (rd_resp == RESP_OKAY) ? model[rd_addr.f.idx] : DATA_W'(0),
                        RDATA);
                compare("RRESP", rd_resp, RRESP);
                compare("RID", rd_id, RID);
                if (RLAST && rd_beat < rd_len) begin
                    err_count++;
                    $display("RLAST came early on beat %0d of %0d", rd_beat, rd_len + 1);
                end else if (!RLAST && rd_beat == rd_len) begin
                    err_count++;
                    $display("RLAST missing on the final beat %0d", rd_beat);
                end
                rd_beat++;
                rd_addr = next_addr(rd_addr, rd_size, rd_burst);
                if (rd_beat == rd_len + 1) begin
                    r_end = 1'b1;
                    close_row("read", rd_id, rd_resp);
                end else begin
                    rv_wait = 2;
                end
            end
            stalled    = RVALID && !RREADY;
            aw_prev    = AWVALID && AWREADY;
            wlast_prev = WVALID && WREADY && WLAST;
            idle_due   = BVALID && BREADY;
            held_data  = RDATA;
            held_resp  = RRESP;
            held_last  = RLAST;
            held_id    = RID;
        end
    end

endmodule

/* bench/tb_sram_axi.sv */
module tb_sram_axi
    import sram_axi_pkg::*;
();

    localparam int   ID_WIDTH = 4;
    localparam logic WR       = 1'b0;
    localparam logic RD       = 1'b1;

    typedef struct packed {
        logic                is_read;
        logic [ID_WIDTH-1:0] id;
        logic [ADDR_W-1:0]   addr;
        logic [LEN_W-1:0]    len;
        logic [SIZE_W-1:0]   size;
        logic [1:0]          burst;
        logic [STRB_W-1:0]   strb;
        logic [DATA_W-1:0]   dseed;
        logic [1:0]          resp;    // Expected response
    } row_t;

    row_t rows[$];
    int   seed = 28;
    int   cycles = 0;
    int   cycle_limit = 0;
    int   err_count, check_count, rows_done;
    logic [1:0] exp_resp;

    logic ACLK, ARESETn;
    logic [ID_WIDTH-1:0] AWID, BID, ARID, RID;
    logic [ADDR_W-1:0]   AWADDR, ARADDR;
    logic [LEN_W-1:0]    AWLEN, ARLEN;
    logic [SIZE_W-1:0]   AWSIZE, ARSIZE;
    logic [1:0]          AWBURST, ARBURST, BRESP, RRESP;
    logic [DATA_W-1:0]   WDATA, RDATA;
    logic [STRB_W-1:0]   WSTRB;
    logic AWVALID, AWREADY, WLAST, WVALID, WREADY, BVALID, BREADY;
    logic ARVALID, ARREADY, RLAST, RVALID, RREADY;

    sram_axi_top #(.ID_WIDTH(ID_WIDTH)) dut_i (.*);

    axi_checker #(.ID_WIDTH(ID_WIDTH)) chk_i (.*);

    always #10 ACLK = ~ACLK;

    always @(posedge ACLK) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, a transaction never finished", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic void add_row(input logic is_read, input logic [ID_WIDTH-1:0] id,
            input logic [ADDR_W-1:0] addr, input logic [LEN_W-1:0] len,
            input logic [SIZE_W-1:0] size, input logic [1:0] burst,
            input logic [STRB_W-1:0] strb, input logic [DATA_W-1:0] dseed,
            input logic [1:0] resp);
        rows.push_back('{is_read, id, addr, len, size, burst, strb, dseed, resp});
    endfunction

    // Ready stays low for 0 to 3 extra cycles
    task automatic random_stall();
        int n;
        n = {$random(seed)} % 4;
        @(negedge ACLK);
        repeat (n) @(negedge ACLK);
    endtask

    task automatic write_burst(input row_t r);
        logic [DATA_W-1:0] data;
        @(negedge ACLK);
        AWID    = r.id;
        AWADDR  = r.addr;
        AWLEN   = r.len;
        AWSIZE  = r.size;
        AWBURST = r.burst;
        AWVALID = 1'b1;
        @(posedge ACLK);
        while (!AWREADY) @(posedge ACLK);
        for (int n = 0; n <= r.len; n++) begin
            data = $random(seed);
            @(negedge ACLK);
            AWVALID = 1'b0;
            WDATA   = data ^ r.dseed;
            WSTRB   = r.strb;
            WLAST   = (n == r.len);
            WVALID  = 1'b1;
            @(posedge ACLK);
            while (!WREADY) @(posedge ACLK);
        end
        @(negedge ACLK);
        WVALID = 1'b0;
        WLAST  = 1'b0;
        @(posedge ACLK);
        while (!BVALID) @(posedge ACLK);
        random_stall();
        BREADY = 1'b1;
        @(negedge ACLK);
        BREADY = 1'b0;
    endtask

    task automatic read_burst(input row_t r);
        @(negedge ACLK);
        ARID    = r.id;
        ARADDR  = r.addr;
        ARLEN   = r.len;
        ARSIZE  = r.size;
        ARBURST = r.burst;
        ARVALID = 1'b1;
        @(posedge ACLK);
        while (!ARREADY) @(posedge ACLK);
        @(negedge ACLK);
        ARVALID = 1'b0;
        for (int n = 0; n <= r.len; n++) begin
            @(posedge ACLK);
            while (!RVALID) @(posedge ACLK);
            random_stall();
            RREADY = 1'b1;
            @(negedge ACLK);
            RREADY = 1'b0;
        end
    endtask

    initial begin
        ACLK = 1'b0;
        ARESETn = 1'b0;
        {AWID, AWADDR, AWLEN, AWSIZE, AWBURST, AWVALID} = '0;
        {WDATA, WSTRB, WLAST, WVALID, BREADY} = '0;
        {ARID, ARADDR, ARLEN, ARSIZE, ARBURST, ARVALID, RREADY} = '0;
        exp_resp = RESP_OKAY;

        add_row(WR, 4'h3, 32'h0001_0010, 0, 2, BURST_INCR, 4'hF, 32'h1234_5678, RESP_OKAY);
        add_row(RD, 4'h5, 32'h0001_0010, 0, 2, BURST_INCR, 4'h0, 32'h0, RESP_OKAY);
        add_row(WR, 4'h1, 32'h0001_0020, 3, 0, BURST_INCR, 4'h1, 32'h0, RESP_OKAY);
        add_row(WR, 4'h2, 32'h0001_0022, 0, 1, BURST_INCR, 4'h3, 32'h0, RESP_OKAY);
        add_row(WR, 4'h2, 32'h0001_0020, 0, 1, BURST_FIXED, 4'h3, 32'h0, RESP_OKAY);
        add_row(RD, 4'h4, 32'h0001_0020, 0, 2, BURST_INCR, 4'h0, 32'h0, RESP_OKAY);
        add_row(WR, 4'h6, 32'h0001_0040, 3, 2, BURST_INCR, 4'hF, 32'h0, RESP_OKAY);
        add_row(RD, 4'h7, 32'h0001_0040, 3, 2, BURST_INCR, 4'h0, 32'h0, RESP_OKAY);
        add_row(WR, 4'h8, 32'h0001_0080, 2, 2, BURST_FIXED, 4'hF, 32'h0, RESP_OKAY);
        add_row(RD, 4'h9, 32'h0001_0080, 0, 2, BURST_FIXED, 4'h0, 32'h0, RESP_OKAY);
        add_row(WR, 4'hA, 32'h0001_0100, 0, 2, BURST_INCR, 4'hF, 32'h0, RESP_OKAY);
        add_row(WR, 4'hB, 32'h0000_0100, 0, 2, BURST_INCR, 4'hF, 32'h0, RESP_SLVERR);
        add_row(RD, 4'hC, 32'h0001_0100, 0, 2, BURST_INCR, 4'h0, 32'h0, RESP_OKAY);
        add_row(RD, 4'hC, 32'h0000_0100, 0, 2, BURST_INCR, 4'h0, 32'h0, RESP_OKAY);
        add_row(WR, 4'hD, 32'h0001_0200, 0, 3, BURST_INCR, 4'hF, 32'h0, RESP_SLVERR);
        add_row(RD, 4'hE, 32'h0001_0040, 1, 3, BURST_INCR, 4'h0, 32'h0, RESP_SLVERR);
        add_row(RD, 4'hF, 32'h0002_0000, 2, 2, BURST_INCR, 4'h0, 32'h0, RESP_DECERR);
        add_row(WR, 4'h0, 32'h0003_0000, 1, 2, BURST_INCR, 4'hF, 32'h0, RESP_DECERR);
        add_row(WR, 4'h1, 32'h0001_0400, 15, 2, BURST_INCR, 4'hF, 32'h5A5A_0000, RESP_OKAY);
        add_row(RD, 4'h2, 32'h0001_0400, 15, 2, BURST_INCR, 4'h0, 32'h0, RESP_OKAY);
        add_row(RD, 4'h3, 32'h0001_0040, 3, 0, BURST_INCR, 4'h0, 32'h0, RESP_OKAY);

        // Beats plus the response, each at worst 8 cycles with stalls
        foreach (rows[i])
            cycle_limit += (int'(rows[i].len) + 2) * 8;
        cycle_limit += 100;

        repeat (8) @(negedge ACLK);
        ARESETn = 1'b1;

        foreach (rows[i]) begin
            @(negedge ACLK);
            exp_resp = rows[i].resp;
            if (rows[i].is_read)
                read_burst(rows[i]);
            else
                write_burst(rows[i]);
        end
        repeat (2) @(negedge ACLK);

        $display("Summary: %0d of %0d rows, %0d checks, %0d errors",
                 rows_done, rows.size(), check_count, err_count);
        if (err_count == 0 && rows_done == rows.size())
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* compile.f */
design/sram_axi_pkg.sv
design/axi_request_ctrl.sv
design/sram_array.sv
design/read_return.sv
design/sram_axi_top.sv
bench/axi_checker.sv
bench/tb_sram_axi.sv

/* Bender.yml */
package:
  name: sram_axi

sources:
  - design/sram_axi_pkg.sv
  - design/axi_request_ctrl.sv
  - design/sram_array.sv
  - design/read_return.sv
  - design/sram_axi_top.sv
  - target: test
    files:
      - bench/axi_checker.sv
      - bench/tb_sram_axi.sv
